// File: flist.f
+incdir+source
source/icache_pkg.sv
source/icache_ways.sv
source/icache_plru.sv
source/icache_control.sv
source/icache_logic.sv
source/icache_top.sv
verification/icache_mem_model.sv
verification/icache_tb.sv

// File: Bender.yml
package:
  name: icache

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/icache_pkg.sv
      - source/icache_ways.sv
      - source/icache_plru.sv
      - source/icache_control.sv
      - source/icache_logic.sv
      - source/icache_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/icache_mem_model.sv
      - verification/icache_tb.sv

// File: verification/icache_tb.sv
`default_nettype none

`include "icache_defines.svh"

module icache_tb
    import icache_pkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_DIRECTED = 11;
    localparam int NUM_TESTS    = NUM_DIRECTED + 12;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  cpu_read;
    addr_t cpu_addr;
    word_t cpu_rdata;
    logic  cpu_resp;
    logic  mem_read;
    addr_t mem_addr;
    line_t mem_rdata;
    logic  mem_resp;
    int    fetch_count;

    string test_name [NUM_TESTS];
    addr_t test_addr [NUM_TESTS];
    int    test_fetch [NUM_TESTS];
    integer seed = 72451;
    int    errors = 0;
    int    passed = 0;

    // Reference cache state
    logic        m_valid [16][4];
    logic [22:0] m_tag   [16][4];
    logic [2:0]  m_tree  [16];

    always #20 clk = ~clk;

    icache_top icache_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_read  (cpu_read),
        .cpu_addr  (cpu_addr),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp),
        .cpu_rdata (cpu_rdata),
        .cpu_resp  (cpu_resp),
        .mem_read  (mem_read),
        .mem_addr  (mem_addr)
    );

    icache_mem_model mem_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_read    (mem_read),
        .mem_addr    (mem_addr),
        .mem_rdata   (mem_rdata),
        .mem_resp    (mem_resp),
        .fetch_count (fetch_count)
    );

    function automatic int model_lookup(addr_t a);
        for (int w = 0; w < 4; w++) begin
            if (m_valid[a[8:5]][w] && m_tag[a[8:5]][w] == a[31:9]) begin
                return w;
            end
        end
        return -1;
    endfunction

    function automatic void model_touch(int idx, int w);
        if (w < 2) begin
            m_tree[idx][0] = 1'b1;
            m_tree[idx][1] = (w == 0);
        end else begin
            m_tree[idx][0] = 1'b0;
            m_tree[idx][2] = (w == 2);
        end
    endfunction

    function automatic void model_fill(addr_t a);
        int idx;
        int w;
        idx = a[8:5];
        w = -1;
        for (int i = 3; i >= 0; i--) begin
            if (!m_valid[idx][i]) w = i;
        end
        if (w < 0) begin
            w = !m_tree[idx][0] ? (m_tree[idx][1] ? 1 : 0) : (m_tree[idx][2] ? 3 : 2);
        end
        m_valid[idx][w] = 1'b1;
        m_tag[idx][w]   = a[31:9];
        model_touch(idx, w);
    endfunction

    // Fetches a request costs: miss fill plus prefetch if the next line is absent
    function automatic int model_access(addr_t a);
        int w;
        addr_t next_line;
        w = model_lookup(a);
        if (w >= 0) begin
            model_touch(a[8:5], w);
            return 0;
        end
        model_fill(a);
        next_line = {a[31:5], 5'd0} + 32'd32;
        if (model_lookup(next_line) >= 0) return 1;
        model_fill(next_line);
        return 2;
    endfunction

    task automatic add_test(int i, string name, addr_t a, int fetches);
        test_name[i]  = name;
        test_addr[i]  = a;
        test_fetch[i] = fetches;
    endtask

    task automatic check_mem_addr(int i, string phase, addr_t exp_addr, inout logic ok);
        assert (mem_addr == exp_addr) else begin
            $display("CHECK FAILED %s %s address: expected %h, actual %h",
                     test_name[i], phase, exp_addr, mem_addr);
            ok = 1'b0;
        end
    endtask

    task automatic run_fetch(int i);
        int    start;
        int    cycles;
        int    exp_fetch;
        word_t exp_word;
        word_t got_word;
        addr_t miss_line;
        logic  ok;
        ok = 1'b1;
        cycles = 0;
        exp_fetch = model_access(test_addr[i]);
        if (test_fetch[i] >= 0) exp_fetch = test_fetch[i];
        exp_word = {test_addr[i][31:2], 2'b00} ^ 32'h5A5A_0000;
        miss_line = {test_addr[i][31:5], 5'd0};
        start = fetch_count;
        cpu_read = 1'b1;
        cpu_addr = test_addr[i];
        do begin
            @(negedge clk);
            cycles++;
            if (mem_read) begin
                check_mem_addr(i, "miss", miss_line, ok);
            end
        end while (!cpu_resp);
        got_word = cpu_rdata;
        cpu_read = 1'b0;
        // Let any prefetch run to completion
        @(negedge clk);
        while (mem_read) begin
            check_mem_addr(i, "prefetch", miss_line + 32'd32, ok);
            @(negedge clk);
        end
        // A prefetch that finds its line present leaves idle one cycle later
        @(negedge clk);
        assert (got_word == exp_word) else begin
            $display("CHECK FAILED %s word: expected %h, actual %h",
                     test_name[i], exp_word, got_word);
            ok = 1'b0;
        end
        assert (fetch_count - start == exp_fetch) else begin
            $display("CHECK FAILED %s fetches: expected %0d, actual %0d",
                     test_name[i], exp_fetch, fetch_count - start);
            ok = 1'b0;
        end
        if (exp_fetch == 0) begin
            assert (cycles == 1) else begin
                $display("CHECK FAILED %s hit latency: expected 1, actual %0d",
                         test_name[i], cycles);
                ok = 1'b0;
            end
        end
        if (ok) passed++;
        else errors++;
        $display("%-20s addr=%h fetches=%0d cycles=%0d %s", test_name[i], test_addr[i],
                 fetch_count - start, cycles, ok ? "ok" : "error");
    endtask

    initial begin
        #((NUM_TESTS + 1) * 40 * 40);
        $display("Timeout: the cache did not answer a fetch in time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic idle_ok;
        rst_n    = 1'b0;
        cpu_read = 1'b0;
        cpu_addr = '0;
        idle_ok  = 1'b1;
        for (int s = 0; s < 16; s++) begin
            m_tree[s] = '0;
            for (int w = 0; w < 4; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        add_test(0, "cold_miss", 32'h0000_1004, 2);
        add_test(1, "same_line", 32'h0000_1018, 0);
        add_test(2, "next_line", 32'h0000_1024, 0);
        add_test(3, "next_present_miss", 32'h0000_0FE0, 1);
        // Five lines in set 3
        add_test(4, "plru_a", 32'h0000_2060, -1);
        add_test(5, "plru_b", 32'h0000_2260, -1);
        add_test(6, "plru_c", 32'h0000_2460, -1);
        add_test(7, "plru_d", 32'h0000_2660, -1);
        add_test(8, "plru_e", 32'h0000_2860, -1);
        add_test(9, "plru_reaccess_a", 32'h0000_2064, -1);
        add_test(10, "plru_reaccess_e", 32'h0000_2868, -1);
        for (int i = NUM_DIRECTED; i < NUM_TESTS; i++) begin
            add_test(i, $sformatf("random_%0d", i - NUM_DIRECTED),
                     32'h0000_4000 + (addr_t'($random(seed)) & 32'h0000_03FC), -1);
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            assert (!cpu_resp && !mem_read) else begin
                $display("Outputs active after reset with no fetch requested");
                idle_ok = 1'b0;
            end
        end
        if (idle_ok) passed++;
        else errors++;
        $display("%-20s %s", "reset_idle", idle_ok ? "ok" : "error");
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_fetch(i);
        end
        $display("Tests: %0d, passed: %0d, errors: %0d", NUM_TESTS + 1, passed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : icache_tb

`default_nettype wire

// File: verification/icache_mem_model.sv
`default_nettype none

`include "icache_defines.svh"

module icache_mem_model
    import icache_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  mem_read,
    input  wire addr_t mem_addr,
    output line_t      mem_rdata,
    output logic       mem_resp,
    output int         fetch_count
);

    timeunit 1ns;
    timeprecision 1ps;

    integer seed = 72451;
    int     delay;
    logic   busy;

    // Every word holds its own byte address XOR a fixed pattern
    function automatic line_t make_line(addr_t base);
        line_t l;
        for (int i = 0; i < `ICACHE_LINE_BITS / 32; i++) begin
            l[i*32 +: 32] = (base + addr_t'(4 * i)) ^ 32'h5A5A_0000;
        end
        return l;
    endfunction

    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rdata   <= '0;
            mem_resp    <= 1'b0;
            fetch_count <= 0;
            busy = 1'b0;
            delay = 0;
        end else begin
            mem_resp <= 1'b0;
            if (mem_read && !mem_resp && !busy) begin
                busy = 1'b1;
                delay = ($unsigned($random(seed)) % 4) + 1;
            end
            if (busy) begin
                delay = delay - 1;
                if (delay == 0) begin
                    busy = 1'b0;
                    mem_resp    <= 1'b1;
                    mem_rdata   <= make_line(mem_addr);
                    fetch_count <= fetch_count + 1;
                end
            end
        end
    end

endmodule : icache_mem_model

`default_nettype wire

// File: source/icache_top.sv
`default_nettype none

`include "icache_defines.svh"

module icache_top
    import icache_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  cpu_read,
    input  wire addr_t cpu_addr,
    input  wire line_t mem_rdata,
    input  wire logic  mem_resp,
    output word_t      cpu_rdata,
    output logic       cpu_resp,
    output logic       mem_read,
    output addr_t      mem_addr
);

    state_t                  state;
    logic                    valid_hit;
    logic                    next_present;
    index_t                  rd_index;
    index_t                  wr_index;
    logic [`ICACHE_WAYS-1:0] way_write;
    tag_t                    way_tag;
    line_t                   way_line;
    logic [`ICACHE_WAYS-1:0] rd_valid;
    tag_t                    rd_tag  [`ICACHE_WAYS];
    line_t                   rd_line [`ICACHE_WAYS];
    logic                    plru_we;
    way_t                    plru_way;
    way_t                    victim_way;

    icache_control icache_control_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_read     (cpu_read),
        .valid_hit    (valid_hit),
        .next_present (next_present),
        .mem_resp     (mem_resp),
        .state        (state),
        .mem_read     (mem_read),
        .cpu_resp     (cpu_resp)
    );

    icache_logic icache_logic_inst (
        .clk          (clk),
        .state        (state),
        .cpu_addr     (cpu_addr),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .rd_valid     (rd_valid),
        .rd_tag       (rd_tag),
        .rd_line      (rd_line),
        .plru_victim  (victim_way),
        .valid_hit    (valid_hit),
        .next_present (next_present),
        .hit_word     (cpu_rdata),
        .mem_addr     (mem_addr),
        .rd_index     (rd_index),
        .way_write    (way_write),
        .wr_index     (wr_index),
        .wr_tag       (way_tag),
        .wr_line      (way_line),
        .plru_we      (plru_we),
        .plru_way     (plru_way)
    );

    icache_ways icache_ways_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_index  (rd_index),
        .way_write (way_write),
        .wr_index  (wr_index),
        .wr_tag    (way_tag),
        .wr_line   (way_line),
        .rd_valid  (rd_valid),
        .rd_tag    (rd_tag),
        .rd_line   (rd_line)
    );

    icache_plru icache_plru_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_index    (rd_index),
        .plru_we     (plru_we),
        .wr_index    (wr_index),
        .plru_way    (plru_way),
        .plru_victim (victim_way)
    );

endmodule : icache_top

`default_nettype wire

// File: source/icache_logic.sv
`default_nettype none

`include "icache_defines.svh"

module icache_logic
    import icache_pkg::*;
(
    input  wire logic                    clk,
    input  wire state_t                  state,
    input  wire addr_t                   cpu_addr,
    input  wire line_t                   mem_rdata,
    input  wire logic                    mem_resp,
    input  wire logic [`ICACHE_WAYS-1:0] rd_valid,
    input  wire tag_t                    rd_tag  [`ICACHE_WAYS],
    input  wire line_t                   rd_line [`ICACHE_WAYS],
    input  wire way_t                    plru_victim,
    output logic                         valid_hit,
    output logic                         next_present,
    output word_t                        hit_word,
    output addr_t                        mem_addr,
    output index_t                       rd_index,
    output logic      [`ICACHE_WAYS-1:0] way_write,
    output index_t                       wr_index,
    output tag_t                         wr_tag,
    output line_t                        wr_line,
    output logic                         plru_we,
    output way_t                         plru_way
);

    localparam int WORD_SEL_BITS = `ICACHE_OFFSET_BITS - 2;

    addr_t                    miss_line_q;
    addr_t                    prefetch_addr;
    addr_t                    lookup_addr;
    tag_t                     lookup_tag;
    index_t                   lookup_index;
    logic [WORD_SEL_BITS-1:0] word_sel;
    logic [`ICACHE_WAYS-1:0]  way_match;
    way_t                     hit_way;
    way_t                     fill_way;
    logic                     invalid_found;
    logic                     fill;
    line_t                    hit_line;

    // Line address of the current fetch, kept for the prefetch after cpu_addr moves on
    always_ff @(posedge clk) begin
        if (state == compare_tag_s) begin
            miss_line_q <= {cpu_addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
                            {`ICACHE_OFFSET_BITS{1'b0}}};
        end
    end

    assign prefetch_addr = miss_line_q + addr_t'(`ICACHE_LINE_BITS / 8);

    assign lookup_addr  = (state == prefetch_s) ? prefetch_addr : cpu_addr;
    assign lookup_tag   = lookup_addr[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
    assign lookup_index = lookup_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign word_sel     = lookup_addr[2 +: WORD_SEL_BITS];

    assign rd_index = lookup_index;

    // Tag compare across the set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_match[w] = rd_valid[w] && (rd_tag[w] == lookup_tag);
            if (way_match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign valid_hit    = |way_match;
    assign next_present = (state == prefetch_s) && valid_hit;

    assign hit_line = rd_line[hit_way];
    assign hit_word = hit_line[word_sel * `ICACHE_WORD_BITS +: `ICACHE_WORD_BITS];

    // Lowest invalid way wins, PLRU only when the set is full
    always_comb begin
        fill_way      = plru_victim;
        invalid_found = 1'b0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (!rd_valid[w] && !invalid_found) begin
                fill_way      = way_t'(w);
                invalid_found = 1'b1;
            end
        end
    end

    assign mem_addr = (state == allocate_s) ? miss_line_q : prefetch_addr;

    assign fill = mem_resp && (state == allocate_s || state == prefetch_s);

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_write[w] = fill && (fill_way == way_t'(w));
        end
    end

    assign wr_index = lookup_index;
    assign wr_tag   = lookup_tag;
    assign wr_line  = mem_rdata;

    // Both a returned hit and a fill count as an access
    assign plru_we  = fill || (state == compare_tag_s && valid_hit);
    assign plru_way = fill ? fill_way : hit_way;

endmodule : icache_logic

`default_nettype wire

// File: source/icache_control.sv
`default_nettype none

`include "icache_defines.svh"

module icache_control
    import icache_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic cpu_read,
    input  wire logic valid_hit,
    input  wire logic next_present,
    input  wire logic mem_resp,
    output state_t    state,
    output logic      mem_read,
    output logic      cpu_resp
);

    state_t next_state;

    // Set once a line is filled on a miss, consumed by the following hit
    logic after_alloc_q;

    always_comb begin
        next_state = state;
        case (state)
            idle_s: begin
                if (cpu_read) begin
                    next_state = compare_tag_s;
                end
            end
            compare_tag_s: begin
                if (!valid_hit) begin
                    next_state = allocate_s;
                end else if (after_alloc_q) begin
                    next_state = prefetch_s;
                end else begin
                    next_state = idle_s;
                end
            end
            allocate_s: begin
                if (mem_resp) begin
                    next_state = compare_tag_s;
                end
            end
            prefetch_s: begin
                // Next line already cached, nothing to fetch
                if (next_present || mem_resp) begin
                    next_state = idle_s;
                end
            end
            default: next_state = idle_s;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= idle_s;
            after_alloc_q <= 1'b0;
        end else begin
            state <= next_state;
            if (state == allocate_s && mem_resp) begin
                after_alloc_q <= 1'b1;
            end else if (state == compare_tag_s && valid_hit) begin
                after_alloc_q <= 1'b0;
            end
        end
    end

    assign cpu_resp = (state == compare_tag_s) && valid_hit;
    assign mem_read = (state == allocate_s) || (state == prefetch_s && !next_present);

endmodule : icache_control

`default_nettype wire

// File: source/icache_plru.sv
`default_nettype none

`include "icache_defines.svh"

module icache_plru
    import icache_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire index_t rd_index,
    input  wire logic   plru_we,
    input  wire index_t wr_index,
    input  wire way_t   plru_way,
    output way_t        plru_victim
);

    plru_t tree_q [`ICACHE_SETS];
    plru_t tree_rd;

    assign tree_rd = tree_q[rd_index];

    // bit0 picks the half, bit1 and bit2 pick within each half
    always_comb begin
        if (!tree_rd[0]) begin
            plru_victim = tree_rd[1] ? way_t'(1) : way_t'(0);
        end else begin
            plru_victim = tree_rd[2] ? way_t'(3) : way_t'(2);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (plru_we) begin
            // Point both levels away from the accessed way
            if (!plru_way[1]) begin
                tree_q[wr_index][0] <= 1'b1;
                tree_q[wr_index][1] <= ~plru_way[0];
            end else begin
                tree_q[wr_index][0] <= 1'b0;
                tree_q[wr_index][2] <= ~plru_way[0];
            end
        end
    end

endmodule : icache_plru

`default_nettype wire

// File: source/icache_ways.sv
`default_nettype none

`include "icache_defines.svh"

module icache_ways
    import icache_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire index_t                    rd_index,
    input  wire logic [`ICACHE_WAYS-1:0]   way_write,
    input  wire index_t                    wr_index,
    input  wire tag_t                      wr_tag,
    input  wire line_t                     wr_line,
    output logic      [`ICACHE_WAYS-1:0]   rd_valid,
    output tag_t                           rd_tag  [`ICACHE_WAYS],
    output line_t                          rd_line [`ICACHE_WAYS]
);

    logic [`ICACHE_WAYS-1:0] valid_q [`ICACHE_SETS];
    tag_t                    tag_q   [`ICACHE_SETS][`ICACHE_WAYS];
    line_t                   line_q  [`ICACHE_SETS][`ICACHE_WAYS];

    // Valid bits are the only state that must be known after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (way_write[w]) begin
                    valid_q[wr_index][w] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (way_write[w]) begin
                tag_q[wr_index][w]  <= wr_tag;
                line_q[wr_index][w] <= wr_line;
            end
        end
    end

    // Combinational read of the whole set
    always_comb begin
        rd_valid = valid_q[rd_index];
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            rd_tag[w]  = tag_q[rd_index][w];
            rd_line[w] = line_q[rd_index][w];
        end
    end

endmodule : icache_ways

`default_nettype wire

// File: source/icache_pkg.sv
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_BITS-1:0] addr_t;
    typedef logic [`ICACHE_WORD_BITS-1:0] word_t;
    typedef logic [`ICACHE_LINE_BITS-1:0] line_t;
    typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;
    typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;

    // One bit per internal node of the tree
    typedef logic [`ICACHE_WAYS-2:0] plru_t;

    typedef enum logic [1:0] {
        idle_s,
        compare_tag_s,
        allocate_s,
        prefetch_s
    } state_t;

endpackage : icache_pkg

`default_nettype wire

// File: source/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Cache organisation
`define ICACHE_WAYS 4
`define ICACHE_SETS 16

// Line and word sizes in bits
`define ICACHE_LINE_BITS 256
`define ICACHE_WORD_BITS 32

// Address split: tag | index | byte offset
`define ICACHE_ADDR_BITS 32
`define ICACHE_INDEX_BITS 4
`define ICACHE_OFFSET_BITS 5
`define ICACHE_TAG_BITS 23

`endif
